/* all.f */
design/branchPkg.sv
design/branchTargetBuffer.sv
design/branchDecode.sv
design/branchExecute.sv
design/branchResult.sv
design/branchPredictTop.sv
tb/branchPredictTb.sv

/* design/branchDecode.sv */
// branch decode stage
// classifies the opcode and records the prediction

module branchDecode (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  logic inReady,
	input  branchPkg::addrT inPc,
	input  branchPkg::instrT inInstr,
	input  branchPkg::operandT inSrcA,
	input  branchPkg::operandT inSrcB,
	output branchPkg::addrT lookupPc,
	input  logic lookupHit,
	input  branchPkg::addrT lookupTarget,
	output logic decValid,
	output branchPkg::addrT decPc,
	output branchPkg::addrT decTarget,
	output branchPkg::addrT decPredNext,
	output branchPkg::branchKindT decKind,
	output branchPkg::operandT decSrcA,
	output branchPkg::operandT decSrcB
);

	logic accept;
	branchPkg::opcodeT opcode;
	branchPkg::branchKindT kind;
	branchPkg::addrT offset;
	branchPkg::addrT directTarget;
	branchPkg::addrT predNext;

	// an instruction moves in only when both sides agree
	assign accept = inValid && inReady;

	assign opcode = inInstr[31:28];

	// opcodes above four are plain instructions
	always_comb
	begin
		case (opcode)
			4'd1: kind = branchPkg::kindBeq;
			4'd2: kind = branchPkg::kindBne;
			4'd3: kind = branchPkg::kindBlt;
			4'd4: kind = branchPkg::kindJump;
			default: kind = branchPkg::kindNone;
		endcase
	end

	// word offset in bits 27:0, sign extended and scaled to bytes
	assign offset = {{(branchPkg::ADDR_W - 30){inInstr[27]}}, inInstr[27:0], 2'b00};
	assign directTarget = inPc + offset;

	// the buffer is looked up with the incoming pc in the same cycle
	assign lookupPc = inPc;

	// fall through unless the buffer knows a taken branch here
	assign predNext = lookupHit ? lookupTarget : inPc + branchPkg::addrT'(4);

	always_ff @(posedge clk)
	begin
		if (rst)
			decValid <= 1'b0;
		else
			decValid <= accept;
	end

	// payload only loads on an accepted instruction
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			decPc <= inPc;
			decKind <= kind;
			decTarget <= directTarget;
			decSrcA <= inSrcA;
			decSrcB <= inSrcB;
			decPredNext <= predNext;
		end
	end

endmodule

/* design/branchExecute.sv */
// branch execute stage
// resolves the condition and checks the prediction

module branchExecute (
	input  logic clk,
	input  logic rst,
	input  logic decValid,
	input  branchPkg::addrT decPc,
	input  branchPkg::branchKindT decKind,
	input  branchPkg::addrT decTarget,
	input  branchPkg::operandT decSrcA,
	input  branchPkg::operandT decSrcB,
	input  branchPkg::addrT decPredNext,
	output logic exeValid,
	output logic exeTaken,
	output logic exeMispredict,
	output branchPkg::addrT exePc,
	output branchPkg::addrT exeNextPc,
	output branchPkg::addrT exeTarget
);

	logic taken;
	logic mispredict;
	branchPkg::addrT actualNext;

	// blt compares the operands as signed values
	always_comb
	begin
		case (decKind)
			branchPkg::kindBeq: taken = (decSrcA == decSrcB);
			branchPkg::kindBne: taken = (decSrcA != decSrcB);
			branchPkg::kindBlt: taken = ($signed(decSrcA) < $signed(decSrcB));
			branchPkg::kindJump: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign actualNext = taken ? decTarget : decPc + branchPkg::addrT'(4);

	// any difference from the predicted pc counts whether the lookup hit or missed
	assign mispredict = decValid && (actualNext != decPredNext);

	always_ff @(posedge clk)
	begin
		if (rst)
			exeValid <= 1'b0;
		else
			exeValid <= decValid;
	end

	// the payload follows the stage every cycle and is qualified by exeValid
	always_ff @(posedge clk)
	begin
		exePc <= decPc;
		exeTaken <= taken;
		exeNextPc <= actualNext;
		exeTarget <= decTarget;
		exeMispredict <= mispredict;
	end

endmodule

/* design/branchPkg.sv */
// branch prediction shared types
// sizes and encodings

package branchPkg;

	// ==========================================================
	// widths
	// ==========================================================

	// program counters and branch targets share one width
	parameter int ADDR_W = 32;

	typedef logic [ADDR_W-1:0] addrT;

	// one instruction word, opcode sits in the top nibble
	typedef logic [31:0] instrT;

	typedef logic [3:0] opcodeT;

	// source operand values as read from the register file
	typedef logic [31:0] operandT;

	// ==========================================================
	// branch kinds
	// ==========================================================

	// encodings follow the opcode values 0 to 4
	// any other opcode decodes as kindNone
	typedef enum logic [2:0] {
		kindNone = 3'd0,
		kindBeq  = 3'd1,
		kindBne  = 3'd2,
		kindBlt  = 3'd3,
		kindJump = 3'd4
	} branchKindT;

	// default sizes, the top level may override both
	parameter int DEF_BTB_ENTRIES = 64;

	// queue depth, also the number of update credits
	parameter int DEF_UPDATE_DEPTH = 4;

endpackage

/* design/branchPredictTop.sv */
// branch prediction top level

module branchPredictTop #(
	parameter int BTB_ENTRIES = branchPkg::DEF_BTB_ENTRIES,
	parameter int UPDATE_DEPTH = branchPkg::DEF_UPDATE_DEPTH
) (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  branchPkg::addrT inPc,
	input  branchPkg::instrT inInstr,
	input  branchPkg::operandT inSrcA,
	input  branchPkg::operandT inSrcB,
	output logic inReady,
	output logic resValid,
	output logic resTaken,
	output logic resMispredict,
	output branchPkg::addrT resPc,
	output branchPkg::addrT resNextPc
);

	// buffer lookup
	branchPkg::addrT lookupPc;
	logic lookupHit;
	branchPkg::addrT lookupTarget;

	// decode to execute
	logic decValid;
	branchPkg::addrT decPc;
	branchPkg::addrT decTarget;
	branchPkg::addrT decPredNext;
	branchPkg::branchKindT decKind;
	branchPkg::operandT decSrcA;
	branchPkg::operandT decSrcB;

	// execute to result
	logic exeValid;
	logic exeTaken;
	logic exeMispredict;
	branchPkg::addrT exePc;
	branchPkg::addrT exeNextPc;
	branchPkg::addrT exeTarget;

	// result to buffer, credit based
	logic updValid;
	logic updTaken;
	branchPkg::addrT updPc;
	branchPkg::addrT updTarget;
	logic updCredit;
	logic stallIn;

	assign inReady = !stallIn;

	branchDecode i_decode (
		.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady),
		.inPc(inPc), .inInstr(inInstr), .inSrcA(inSrcA), .inSrcB(inSrcB),
		.lookupPc(lookupPc), .lookupHit(lookupHit), .lookupTarget(lookupTarget),
		.decValid(decValid), .decPc(decPc), .decTarget(decTarget),
		.decPredNext(decPredNext), .decKind(decKind),
		.decSrcA(decSrcA), .decSrcB(decSrcB)
	);

	branchExecute i_execute (
		.clk(clk), .rst(rst), .decValid(decValid), .decPc(decPc),
		.decKind(decKind), .decTarget(decTarget), .decSrcA(decSrcA),
		.decSrcB(decSrcB), .decPredNext(decPredNext),
		.exeValid(exeValid), .exeTaken(exeTaken), .exeMispredict(exeMispredict),
		.exePc(exePc), .exeNextPc(exeNextPc), .exeTarget(exeTarget)
	);

	branchResult #(.UPDATE_DEPTH(UPDATE_DEPTH)) i_result (
		.clk(clk), .rst(rst), .exeValid(exeValid), .exeTaken(exeTaken),
		.exeMispredict(exeMispredict), .exePc(exePc), .exeNextPc(exeNextPc),
		.exeTarget(exeTarget), .resValid(resValid), .resTaken(resTaken),
		.resMispredict(resMispredict), .resPc(resPc), .resNextPc(resNextPc),
		.updValid(updValid), .updTaken(updTaken), .updPc(updPc),
		.updTarget(updTarget), .updCredit(updCredit), .stallIn(stallIn)
	);

	branchTargetBuffer #(
		.BTB_ENTRIES(BTB_ENTRIES),
		.UPDATE_DEPTH(UPDATE_DEPTH)
	) i_btb (
		.clk(clk), .rst(rst), .lookupPc(lookupPc), .lookupHit(lookupHit),
		.lookupTarget(lookupTarget), .updValid(updValid), .updPc(updPc),
		.updTarget(updTarget), .updTaken(updTaken), .updCredit(updCredit)
	);

endmodule

/* design/branchResult.sv */
// branch result stage
// reports outcomes and sends buffer updates under credit

module branchResult #(
	parameter int UPDATE_DEPTH = branchPkg::DEF_UPDATE_DEPTH
) (
	input  logic clk,
	input  logic rst,
	input  logic exeValid,
	input  logic exeTaken,
	input  logic exeMispredict,
	input  branchPkg::addrT exePc,
	input  branchPkg::addrT exeNextPc,
	input  branchPkg::addrT exeTarget,
	output logic resValid,
	output logic resTaken,
	output logic resMispredict,
	output branchPkg::addrT resPc,
	output branchPkg::addrT resNextPc,
	output logic updValid,
	output logic updTaken,
	output branchPkg::addrT updPc,
	output branchPkg::addrT updTarget,
	input  logic updCredit,
	output logic stallIn
);

	localparam int CNT_W = $clog2(UPDATE_DEPTH + 1);

	branchPkg::addrT resTarget;
	logic [CNT_W-1:0] creditCnt;
	logic holdValid;
	logic holdTaken;
	branchPkg::addrT holdPc;
	branchPkg::addrT holdTarget;
	logic newUpd;
	logic sendHold;
	logic sendNew;
	logic loadHold;

	// ==========================================================
	// result registers
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			resValid <= 1'b0;
		else
			resValid <= exeValid;
	end

	always_ff @(posedge clk)
	begin
		resPc <= exePc;
		resTaken <= exeTaken;
		resNextPc <= exeNextPc;
		resTarget <= exeTarget;
		resMispredict <= exeMispredict;
	end

	// ==========================================================
	// update channel
	// ==========================================================

	// every mispredict trains the buffer with the actual outcome
	assign newUpd = resValid && resMispredict;

	// a held update goes first so the buffer sees updates in order
	assign sendHold = holdValid && (creditCnt != '0);
	assign sendNew = newUpd && !holdValid && (creditCnt != '0);

	// anything not sent this cycle waits, even while hold itself drains
	assign loadHold = newUpd && !sendNew;

	assign updValid = sendHold || sendNew;
	assign updPc = holdValid ? holdPc : resPc;
	assign updTarget = holdValid ? holdTarget : resTarget;
	assign updTaken = holdValid ? holdTaken : resTaken;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			holdValid <= 1'b0;
			creditCnt <= CNT_W'(UPDATE_DEPTH);
		end
		else
		begin
			if (loadHold)
				holdValid <= 1'b1;
			else if (sendHold)
				holdValid <= 1'b0;
			case ({updValid, updCredit})
				2'b10: creditCnt <= creditCnt - 1'b1;
				2'b01: creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadHold)
		begin
			holdPc <= resPc;
			holdTarget <= resTarget;
			holdTaken <= resTaken;
		end
	end

	// hold input while an update waits, or while work is in flight and credits are gone
	assign stallIn = holdValid || ((exeValid || resValid) && (creditCnt == '0));

	// credits come back only for entries sent earlier
	assert property (@(posedge clk) disable iff (rst)
		creditCnt <= CNT_W'(UPDATE_DEPTH))
		else $error("credit count above queue depth");

	// a stuck hold entry must not be overwritten by the next mispredict
	assert property (@(posedge clk) disable iff (rst)
		(holdValid && !sendHold) |-> !newUpd)
		else $error("update lost in the hold register");

endmodule

/* design/branchTargetBuffer.sv */
// branch target buffer
// direct-mapped table with a credit-fed update queue

module branchTargetBuffer #(
	parameter int BTB_ENTRIES = branchPkg::DEF_BTB_ENTRIES,
	parameter int UPDATE_DEPTH = branchPkg::DEF_UPDATE_DEPTH
) (
	input  logic clk,
	input  logic rst,
	input  branchPkg::addrT lookupPc,
	output logic lookupHit,
	output branchPkg::addrT lookupTarget,
	input  logic updValid,
	input  branchPkg::addrT updPc,
	input  branchPkg::addrT updTarget,
	input  logic updTaken,
	output logic updCredit
);

	// index bits sit above the two low pc bits
	localparam int IDX_W = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;
	localparam int TBL_SIZE = 2 ** IDX_W;
	localparam int PTR_W = (UPDATE_DEPTH > 1) ? $clog2(UPDATE_DEPTH) : 1;
	localparam int CNT_W = $clog2(UPDATE_DEPTH + 1);

	// ==========================================================
	// update queue
	// ==========================================================

	branchPkg::addrT qPc [UPDATE_DEPTH];
	branchPkg::addrT qTarget [UPDATE_DEPTH];
	logic qTaken [UPDATE_DEPTH];
	logic [PTR_W-1:0] headPtr;
	logic [PTR_W-1:0] tailPtr;
	logic [CNT_W-1:0] qCount;
	logic popEn;

	// pointers wrap at the queue depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(UPDATE_DEPTH - 1))
			nxt = '0;
		else
			nxt = ptr + 1'b1;
		return nxt;
	endfunction

	// one queued entry drains into the table every cycle it is non-empty
	assign popEn = (qCount != '0);

	// each drained entry frees a slot, so hand a credit back right away
	assign updCredit = popEn;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			qCount <= '0;
		end
		else
		begin
			if (updValid)
				tailPtr <= nextPtr(tailPtr);
			if (popEn)
				headPtr <= nextPtr(headPtr);
			case ({updValid, popEn})
				2'b10: qCount <= qCount + 1'b1;
				2'b01: qCount <= qCount - 1'b1;
				default: qCount <= qCount;
			endcase
		end
	end

	// queue payload, written at the tail without reset
	always_ff @(posedge clk)
	begin
		if (updValid)
		begin
			qPc[tailPtr] <= updPc;
			qTarget[tailPtr] <= updTarget;
			qTaken[tailPtr] <= updTaken;
		end
	end

	// ==========================================================
	// target table
	// ==========================================================

	logic [TBL_SIZE-1:0] tblValid;
	logic tblTaken [TBL_SIZE];
	branchPkg::addrT tblTag [TBL_SIZE];
	branchPkg::addrT tblTarget [TBL_SIZE];
	logic [IDX_W-1:0] lookupIdx;
	logic [IDX_W-1:0] writeIdx;

	assign writeIdx = qPc[headPtr][IDX_W+1:2];

	// only the valid bits need clearing, the rest is ignored until then
	always_ff @(posedge clk)
	begin
		if (rst)
			tblValid <= '0;
		else if (popEn)
			tblValid[writeIdx] <= 1'b1;
	end

	// the full pc is kept as tag so aliases never hit
	always_ff @(posedge clk)
	begin
		if (popEn)
		begin
			tblTag[writeIdx] <= qPc[headPtr];
			tblTarget[writeIdx] <= qTarget[headPtr];
			tblTaken[writeIdx] <= qTaken[headPtr];
		end
	end

	// lookup is combinational and sees a write one cycle after its edge
	assign lookupIdx = lookupPc[IDX_W+1:2];
	assign lookupHit = tblValid[lookupIdx] && tblTaken[lookupIdx]
		&& (tblTag[lookupIdx] == lookupPc);
	assign lookupTarget = tblTarget[lookupIdx];

	// the sender's credit count must keep a free slot for every push
	assert property (@(posedge clk) disable iff (rst)
		updValid |-> (qCount < CNT_W'(UPDATE_DEPTH)))
		else $error("update pushed into a full queue");

	// a drain only happens while the pointers show a stored entry
	assert property (@(posedge clk) disable iff (rst)
		updCredit |-> ((headPtr != tailPtr) || (qCount == CNT_W'(UPDATE_DEPTH))))
		else $error("update queue drained while empty");

endmodule

/* run.sh */
#!/bin/sh
# build and run the branch prediction testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module branchPredictTb -f all.f -o simv

# the simulator status is masked by tee, the log search decides
./obj_dir/simv | tee sim.log
grep -q "STATUS: PASS" sim.log
echo "simulation passed"

/* tb/branchCases.txt */
# pc instr srcA srcB gap taken nextPc mispredict
# all hex, gap is the number of idle cycles before the instruction
00001000 00000010 00000000 00000000 2 0 00001004 0
00001004 70000005 00000000 00000000 0 0 00001008 0
00001008 10000004 00000001 00000002 0 0 0000100c 0
0000100c 20000008 00000005 00000005 0 0 00001010 0
00001010 30000002 00000003 fffffffe 0 0 00001014 0
00001100 10000010 00000007 00000007 0 1 00001140 1
00001204 2ffffffc 00000001 00000002 0 1 000011f4 1
00001308 30000020 fffffff0 fffffffc 0 1 00001388 1
0000140c 40000100 00000000 00000000 0 1 0000180c 1
00001100 10000010 00000007 00000007 8 1 00001140 0
00001204 2ffffffc 00000001 00000002 0 1 000011f4 0
00001308 30000020 fffffff0 fffffffc 0 1 00001388 0
0000140c 40000100 00000000 00000000 0 1 0000180c 0
00001100 10000010 00000007 00000008 0 0 00001104 1
00001100 10000010 00000007 00000008 8 0 00001104 0
00001100 10000010 00000007 00000007 0 1 00001140 1
00001200 10000010 00000003 00000004 8 0 00001204 0
00001200 10000010 00000003 00000003 0 1 00001240 1
00001100 10000010 00000007 00000007 8 1 00001140 1
00001200 10000010 00000003 00000003 8 1 00001240 1
00002000 40000040 00000000 00000000 8 1 00002100 1
00002004 40000040 00000000 00000000 0 1 00002104 1
00002008 40000040 00000000 00000000 0 1 00002108 1
0000200c 40000040 00000000 00000000 0 1 0000210c 1
00002010 40000040 00000000 00000000 0 1 00002110 1
00002014 40000040 00000000 00000000 0 1 00002114 1
00002014 40000040 00000000 00000000 8 1 00002114 0

/* tb/branchPredictTb.sv */
// branch prediction testbench
// replays the case file through the pipeline

module branchPredictTb;

	logic clk;
	logic rst;
	logic inValid;
	branchPkg::addrT inPc;
	branchPkg::instrT inInstr;
	branchPkg::operandT inSrcA;
	branchPkg::operandT inSrcB;
	logic inReady;
	logic resValid;
	logic resTaken;
	logic resMispredict;
	branchPkg::addrT resPc;
	branchPkg::addrT resNextPc;

	// each list holds one entry per case line in case number order
	logic [31:0] pcList[$];
	logic [31:0] instrList[$];
	logic [31:0] srcAList[$];
	logic [31:0] srcBList[$];
	int gapList[$];
	logic takenList[$];
	logic [31:0] nextList[$];
	logic mispList[$];

	// case numbers of accepted instructions with the oldest at the front
	int expectQ[$];

	int caseCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	bit limitReady = 1'b0;

	branchPredictTop i_branchPredictTop (
		.clk(clk), .rst(rst), .inValid(inValid), .inPc(inPc),
		.inInstr(inInstr), .inSrcA(inSrcA), .inSrcB(inSrcB),
		.inReady(inReady), .resValid(resValid), .resTaken(resTaken),
		.resMispredict(resMispredict), .resPc(resPc), .resNextPc(resNextPc)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==========================================================
	// helpers
	// ==========================================================

	task automatic failRun();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// lines starting with # describe the columns and are skipped
	task automatic loadCases();
		int fd;
		int rc;
		int gapSum;
		string line;
		logic [31:0] vPc;
		logic [31:0] vInstr;
		logic [31:0] vA;
		logic [31:0] vB;
		logic [31:0] vGap;
		logic [31:0] vTaken;
		logic [31:0] vNext;
		logic [31:0] vMisp;
		gapSum = 0;
		fd = $fopen("tb/branchCases.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("could not open the case file tb/branchCases.txt");
			failRun();
		end
		while (!$feof(fd))
		begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) != "#")
			begin
				rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
					vPc, vInstr, vA, vB, vGap, vTaken, vNext, vMisp);
				assert (rc == 8 || rc <= 0)
				else
				begin
					$display("case file line has %0d fields instead of 8", rc);
					failRun();
				end
				if (rc == 8)
				begin
					pcList.push_back(vPc);
					instrList.push_back(vInstr);
					srcAList.push_back(vA);
					srcBList.push_back(vB);
					gapList.push_back(int'(vGap));
					takenList.push_back(vTaken[0]);
					nextList.push_back(vNext);
					mispList.push_back(vMisp[0]);
					gapSum = gapSum + int'(vGap);
				end
			end
		end
		$fclose(fd);
		caseCount = pcList.size();
		assert (caseCount > 0)
		else
		begin
			$display("the case file holds no cases");
			failRun();
		end
		// every case costs its gap plus one accept cycle and the margin covers reset and drain
		cycleLimit = gapSum + caseCount + 50;
		limitReady = 1'b1;
	endtask

	// idle for the gap and hold the instruction until inReady lets it in
	task automatic driveCase(input int n);
		repeat (gapList[n])
		begin
			@(posedge clk);
			#1;
		end
		inValid = 1'b1;
		inPc = pcList[n];
		inInstr = instrList[n];
		inSrcA = srcAList[n];
		inSrcB = srcBList[n];
		@(negedge clk);
		while (inReady != 1'b1)
			@(negedge clk);
		// ready at mid cycle means the next rising edge takes it
		expectQ.push_back(n);
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	task automatic checkResult();
		int idx;
		idx = expectQ.pop_front();
		assert (resPc == pcList[idx])
		else
		begin
			$display("FAILED at %0t: case %0d result pc %h, expected %h",
				$time, idx, resPc, pcList[idx]);
			failRun();
		end
		assert (resTaken == takenList[idx])
		else
		begin
			$display("FAILED at %0t: case %0d pc %h taken %b, expected %b",
				$time, idx, resPc, resTaken, takenList[idx]);
			failRun();
		end
		assert (resNextPc == nextList[idx])
		else
		begin
			$display("FAILED at %0t: case %0d pc %h next pc %h, expected %h",
				$time, idx, resPc, resNextPc, nextList[idx]);
			failRun();
		end
		assert (resMispredict == mispList[idx])
		else
		begin
			$display("FAILED at %0t: case %0d pc %h mispredict %b, expected %b",
				$time, idx, resPc, resMispredict, mispList[idx]);
			failRun();
		end
	endtask

	// ==========================================================
	// checking and run limit
	// ==========================================================

	// results are sampled mid cycle where the registered outputs are settled
	always @(negedge clk)
	begin
		if (rst == 1'b0 && resValid == 1'b1)
		begin
			assert (expectQ.size() != 0)
			else
			begin
				$display("a result came out with no instruction in flight at %0t", $time);
				failRun();
			end
			if (expectQ.size() != 0)
				checkResult();
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (limitReady && cycleCount > cycleLimit)
		begin
			$display("timeout, the run did not finish within %0d cycles", cycleLimit);
			failRun();
		end
	end

	// ==========================================================
	// main sequence
	// ==========================================================

	initial
	begin
		rst = 1'b1;
		inValid = 1'b0;
		inPc = '0;
		inInstr = '0;
		inSrcA = '0;
		inSrcB = '0;
		loadCases();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int n = 0; n < caseCount; n++)
			driveCase(n);
		// let the pipeline drain and watch a few more cycles for stray results
		while (expectQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		// with nothing in flight and no update held the input side is ready again
		if (inReady == 1'b1)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			$display("the input side stayed stalled after the pipeline drained");
			failRun();
		end
	end

endmodule
